// ==== flist.f ====
+incdir+rtl
rtl/decode_pkg.sv
rtl/decode_controller.sv
rtl/field_decoder.sv
rtl/hazard_detector.sv
rtl/reg_file.sv
rtl/decode_exe_reg.sv
rtl/decode_stage.sv
dv/decode_stage_sva.sv
dv/decode_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
FAIL_TEXT="Checks failed"

verilator --binary --timing --assert \
  -f flist.f \
  --top-module decode_stage_tb \
  -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vdecode_stage_tb" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if grep -q "$FAIL_TEXT" "$LOG_FILE"; then
  echo "simulation reported a failure"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
echo "simulation finished without failures"
exit 0

// ==== dv/decode_stage_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "decode_settings.svh"

module decode_stage_tb;

  import decode_pkg::*;

  localparam int RESET_CYCLES    = 16;
  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 330;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST;
  localparam int ACCEPT_LIMIT    = 20;

  logic      clk_i;
  logic      rst_n_i;
  logic      valid_i;
  word_t     instr_i;
  word_t     pc_i;
  logic      stall_o;
  logic      flush_i;
  logic      credit_i;
  logic      wb_en_i;
  reg_addr_t wb_addr_i;
  word_t     wb_data_i;
  logic      ex_valid_o;
  alu_op_t   ex_alu_op_o;
  logic      ex_alu_b_imm_o;
  logic      ex_mem_read_o;
  logic      ex_mem_write_o;
  logic      ex_reg_write_o;
  logic      ex_branch_o;
  reg_addr_t ex_dest_o;
  reg_addr_t ex_src1_o;
  reg_addr_t ex_src2_o;
  word_t     ex_op1_o;
  word_t     ex_op2_o;
  word_t     ex_store_data_o;
  word_t     ex_imm_o;
  word_t     ex_pc_o;

  // execute model controls and the expected register contents
  logic        credit_en;
  logic        pulse_credit;
  word_t       model_regs [16];

  decode_stage decode_stage_inst (.*);

  bind decode_stage decode_stage_sva decode_stage_sva_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .valid_i      (valid_i),
    .instr_i      (instr_i),
    .pc_i         (pc_i),
    .stall_o      (stall_o),
    .flush_i      (flush_i),
    .ex_valid_o   (ex_valid_o),
    .credit_cnt_i (decode_exe_reg_inst.credit_cnt)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    end_in_failure("watchdog expired before the tests finished");
  end

  ////////////////////////////////////////////////////////////////////////////
  // reporting and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic end_in_failure(input string line);
    $display("%s", line);
    $display("Checks failed");
    $fatal(1, "run stopped");
  endtask

  task automatic report_mismatch(input string msg);
    end_in_failure($sformatf("FAILED at time %0t: %s", $time, msg));
  endtask

  task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp) report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
  endtask

  task automatic check_addr(input string what, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) report_mismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
  endtask

  task automatic check_alu(input string what, input alu_op_t got, input alu_op_t exp);
    if (got !== exp) report_mismatch($sformatf("%s is %s, expected %s", what, got.name(),
                                               exp.name()));
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic word_t encode_instr(input opcode_t op, input reg_addr_t rd,
                                         input reg_addr_t rs1, input logic [3:0] low);
    return {op, rd, rs1, low};
  endfunction

  function automatic word_t sign_extend4(input logic [3:0] field);
    return {{(`DEC_WORD-4){field[3]}}, field};
  endfunction

  function automatic alu_op_t expected_alu(input opcode_t op);
    case (op)
      SUB, BEQZ: return ALU_SUB;
      AND:       return ALU_AND;
      OR:        return ALU_OR;
      default:   return ALU_ADD;
    endcase
  endfunction

  // advance one clock and drive 1 ns later
  // execute returns a credit for each beat it receives
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
    credit_i     = pulse_credit || (credit_en && ex_valid_o);
    pulse_credit = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    valid_i = 1'b0;
    repeat (n) next_cycle();
  endtask

  task automatic write_reg(input reg_addr_t addr, input word_t data);
    wb_en_i   = 1'b1;
    wb_addr_i = addr;
    wb_data_i = data;
    next_cycle();
    wb_en_i = 1'b0;
    if (addr != '0) model_regs[addr] = data;
  endtask

  // present one instruction and return once decode has taken it
  task automatic send_instr(input word_t instr, input word_t pc);
    int waited;
    waited  = 0;
    valid_i = 1'b1;
    instr_i = instr;
    pc_i    = pc;
    #1;
    while (stall_o) begin
      if (waited == ACCEPT_LIMIT) end_in_failure("decode never accepted an instruction");
      waited++;
      next_cycle();
      #1;
    end
    next_cycle();
    valid_i = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic alu_register_ops();
    opcode_t   ops [4];
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    ops = '{ADD, SUB, AND, OR};
    for (int i = 1; i < 16; i++) write_reg(reg_addr_t'(i), word_t'($urandom));
    // r0 ignores the write
    write_reg(reg_addr_t'(0), word_t'($urandom));
    for (int i = 0; i < 8; i++) begin
      rd  = reg_addr_t'($urandom_range(15, 1));
      rs1 = (i == 0) ? reg_addr_t'(0) : reg_addr_t'($urandom_range(15, 0));
      rs2 = (i == 0) ? reg_addr_t'(0) : reg_addr_t'($urandom_range(15, 0));
      send_instr(encode_instr(ops[i % 4], rd, rs1, rs2), word_t'(32'h100 + i));
      check_bit("ex_valid_o", ex_valid_o, 1'b1);
      check_alu("ex_alu_op_o", ex_alu_op_o, expected_alu(ops[i % 4]));
      check_bit("ex_alu_b_imm_o", ex_alu_b_imm_o, 1'b0);
      check_bit("ex_reg_write_o", ex_reg_write_o, 1'b1);
      check_bit("ex_mem_write_o", ex_mem_write_o, 1'b0);
      check_addr("ex_dest_o", ex_dest_o, rd);
      check_addr("ex_src1_o", ex_src1_o, rs1);
      check_addr("ex_src2_o", ex_src2_o, rs2);
      check_word("ex_op1_o", ex_op1_o, (rs1 == '0) ? word_t'(0) : model_regs[rs1]);
      check_word("ex_op2_o", ex_op2_o, (rs2 == '0) ? word_t'(0) : model_regs[rs2]);
      check_word("ex_pc_o", ex_pc_o, word_t'(32'h100 + i));
    end
    idle_cycles(1);
    check_bit("ex_valid_o after last issue", ex_valid_o, 1'b0);
  endtask

  task automatic immediate_forms();
    opcode_t    ops [3];
    logic [3:0] imms [3];
    reg_addr_t  rd;
    reg_addr_t  rs1;
    ops  = '{ADDI, ST, LD};
    imms = '{4'hA, 4'h7, 4'h8};
    for (int i = 0; i < 3; i++) begin
      rd  = reg_addr_t'($urandom_range(15, 1));
      rs1 = reg_addr_t'($urandom_range(15, 1));
      send_instr(encode_instr(ops[i], rd, rs1, imms[i]), word_t'(32'h200 + i));
      check_bit("ex_valid_o", ex_valid_o, 1'b1);
      check_word("ex_imm_o", ex_imm_o, sign_extend4(imms[i]));
      check_alu("ex_alu_op_o", ex_alu_op_o, ALU_ADD);
      check_bit("ex_alu_b_imm_o", ex_alu_b_imm_o, 1'b1);
      check_bit("ex_mem_read_o", ex_mem_read_o, ops[i] == LD);
      check_bit("ex_mem_write_o", ex_mem_write_o, ops[i] == ST);
      check_bit("ex_reg_write_o", ex_reg_write_o, ops[i] != ST);
      check_addr("ex_src1_o", ex_src1_o, rs1);
      check_addr("ex_src2_o", ex_src2_o, reg_addr_t'(0));
      check_word("ex_op1_o", ex_op1_o, model_regs[rs1]);
      if (ops[i] == ST) check_word("ex_store_data_o", ex_store_data_o, model_regs[rd]);
    end
    idle_cycles(2);
  endtask

  task automatic writeback_bypass();
    reg_addr_t k;
    reg_addr_t k2;
    word_t     fresh;
    k     = reg_addr_t'($urandom_range(15, 1));
    k2    = (k == reg_addr_t'(15)) ? reg_addr_t'(1) : k + reg_addr_t'(1);
    fresh = word_t'($urandom);
    wb_en_i   = 1'b1;
    wb_addr_i = k;
    wb_data_i = fresh;
    send_instr(encode_instr(ADD, reg_addr_t'(2), k, k), word_t'(32'h300));
    wb_en_i = 1'b0;
    model_regs[k] = fresh;
    check_word("ex_op1_o bypass", ex_op1_o, fresh);
    check_word("ex_op2_o bypass", ex_op2_o, fresh);
    // store data port sees the same bypass
    fresh     = word_t'($urandom);
    wb_en_i   = 1'b1;
    wb_addr_i = k2;
    wb_data_i = fresh;
    send_instr(encode_instr(ST, k2, reg_addr_t'(0), 4'h0), word_t'(32'h301));
    wb_en_i = 1'b0;
    model_regs[k2] = fresh;
    check_word("ex_store_data_o bypass", ex_store_data_o, fresh);
    send_instr(encode_instr(OR, reg_addr_t'(2), k, k2), word_t'(32'h302));
    check_word("ex_op1_o after write", ex_op1_o, model_regs[k]);
    check_word("ex_op2_o after write", ex_op2_o, model_regs[k2]);
    idle_cycles(2);
  endtask

  task automatic load_use_bubble();
    valid_i = 1'b1;
    instr_i = encode_instr(LD, reg_addr_t'(3), reg_addr_t'(1), 4'h0);
    pc_i    = word_t'(32'h400);
    #1;
    check_bit("stall_o on load", stall_o, 1'b0);
    next_cycle();
    check_bit("ex_mem_read_o", ex_mem_read_o, 1'b1);
    check_addr("ex_dest_o", ex_dest_o, reg_addr_t'(3));
    instr_i = encode_instr(ADD, reg_addr_t'(5), reg_addr_t'(3), 4'd2);
    pc_i    = word_t'(32'h401);
    #1;
    check_bit("stall_o on load-use", stall_o, 1'b1);
    next_cycle();
    check_bit("ex_valid_o bubble", ex_valid_o, 1'b0);
    #1;
    check_bit("stall_o after bubble", stall_o, 1'b0);
    next_cycle();
    valid_i = 1'b0;
    check_bit("ex_valid_o", ex_valid_o, 1'b1);
    check_addr("ex_dest_o", ex_dest_o, reg_addr_t'(5));
    check_word("ex_op1_o", ex_op1_o, model_regs[3]);
    check_word("ex_op2_o", ex_op2_o, model_regs[2]);
    idle_cycles(2);
  endtask

  task automatic credit_back_pressure();
    idle_cycles(3);
    credit_en = 1'b0;
    valid_i   = 1'b1;
    for (int i = 0; i < `DEC_CREDITS; i++) begin
      instr_i = encode_instr(OR, reg_addr_t'(i + 1), reg_addr_t'(1), 4'd2);
      pc_i    = word_t'(32'h500 + i);
      #1;
      check_bit("stall_o with credits left", stall_o, 1'b0);
      next_cycle();
      check_bit("ex_valid_o", ex_valid_o, 1'b1);
      check_word("ex_pc_o", ex_pc_o, word_t'(32'h500 + i));
    end
    for (int n = 0; n < 2; n++) begin
      instr_i = encode_instr(AND, reg_addr_t'(9), reg_addr_t'(1), 4'd2);
      pc_i    = word_t'(32'h580 + n);
      repeat (3) begin
        #1;
        check_bit("stall_o without credits", stall_o, 1'b1);
        next_cycle();
        check_bit("ex_valid_o without credits", ex_valid_o, 1'b0);
      end
      // one returned credit lets exactly one instruction through
      pulse_credit = 1'b1;
      next_cycle();
      #1;
      check_bit("stall_o with returned credit", stall_o, 1'b0);
      next_cycle();
      check_bit("ex_valid_o after credit", ex_valid_o, 1'b1);
      check_word("ex_pc_o after credit", ex_pc_o, word_t'(32'h580 + n));
    end
    valid_i = 1'b0;
    // execute drains what is still in flight
    repeat (`DEC_CREDITS) begin
      pulse_credit = 1'b1;
      next_cycle();
      next_cycle();
    end
    credit_en = 1'b1;
  endtask

  task automatic store_pair_and_flush();
    valid_i = 1'b1;
    instr_i = encode_instr(STP, reg_addr_t'(6), reg_addr_t'(1), 4'h2);
    pc_i    = word_t'(32'h600);
    #1;
    check_bit("stall_o on first beat", stall_o, 1'b1);
    next_cycle();
    check_bit("ex_mem_write_o", ex_mem_write_o, 1'b1);
    check_word("ex_store_data_o first beat", ex_store_data_o, model_regs[6]);
    check_word("ex_op1_o first beat", ex_op1_o, model_regs[1]);
    check_word("ex_imm_o", ex_imm_o, sign_extend4(4'h2));
    #1;
    check_bit("stall_o on second beat", stall_o, 1'b0);
    next_cycle();
    check_bit("ex_valid_o second beat", ex_valid_o, 1'b1);
    check_word("ex_store_data_o second beat", ex_store_data_o, model_regs[7]);
    check_word("ex_op1_o second beat", ex_op1_o, model_regs[1]);
    // flush while the second beat is pending
    instr_i = encode_instr(STP, reg_addr_t'(10), reg_addr_t'(2), 4'h0);
    pc_i    = word_t'(32'h610);
    next_cycle();
    check_word("ex_store_data_o before flush", ex_store_data_o, model_regs[10]);
    flush_i = 1'b1;
    #1;
    check_bit("stall_o during flush", stall_o, 1'b1);
    next_cycle();
    flush_i = 1'b0;
    check_bit("ex_valid_o after flush", ex_valid_o, 1'b0);
    instr_i = encode_instr(ST, reg_addr_t'(10), reg_addr_t'(2), 4'h1);
    pc_i    = word_t'(32'h620);
    #1;
    check_bit("stall_o after flush", stall_o, 1'b0);
    next_cycle();
    valid_i = 1'b0;
    check_bit("ex_valid_o after redirect", ex_valid_o, 1'b1);
    check_word("ex_store_data_o after redirect", ex_store_data_o, model_regs[10]);
    check_word("ex_pc_o after redirect", ex_pc_o, word_t'(32'h620));
    idle_cycles(2);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(31427));
    rst_n_i      = 1'b0;
    valid_i      = 1'b0;
    instr_i      = '0;
    pc_i         = '0;
    flush_i      = 1'b0;
    credit_i     = 1'b0;
    wb_en_i      = 1'b0;
    wb_addr_i    = '0;
    wb_data_i    = '0;
    credit_en    = 1'b1;
    pulse_credit = 1'b0;
    for (int i = 0; i < 16; i++) model_regs[i] = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    #1;
    check_bit("ex_valid_o after reset", ex_valid_o, 1'b0);
    check_bit("ex_mem_read_o after reset", ex_mem_read_o, 1'b0);
    check_bit("ex_mem_write_o after reset", ex_mem_write_o, 1'b0);
    check_bit("ex_reg_write_o after reset", ex_reg_write_o, 1'b0);
    check_bit("ex_branch_o after reset", ex_branch_o, 1'b0);
    check_bit("stall_o after reset", stall_o, 1'b0);
    next_cycle();
    alu_register_ops();
    immediate_forms();
    writeback_bypass();
    load_use_bubble();
    credit_back_pressure();
    store_pair_and_flush();
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/decode_stage_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "decode_settings.svh"

module decode_stage_sva (
  input  wire logic                clk_i,
  input  wire logic                rst_n_i,
  input  wire logic                valid_i,
  input  decode_pkg::word_t        instr_i,
  input  decode_pkg::word_t        pc_i,
  input  wire logic                stall_o,
  input  wire logic                flush_i,
  input  wire logic                ex_valid_o,
  input  decode_pkg::credit_cnt_t  credit_cnt_i
);

  import decode_pkg::*;

  // an underflow wraps to a large value, so the upper bound covers both ends
  credits_in_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    credit_cnt_i <= credit_cnt_t'(`DEC_CREDITS))
    else $error("credit counter left the range 0..%0d", `DEC_CREDITS);

  flush_kills_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |=> !ex_valid_o)
    else $error("ex_valid_o high the cycle after a flush");

  // fetch holds its outputs while stalled, a flush redirects it
  fetch_holds_on_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_i && stall_o && !flush_i |=> valid_i && $stable(instr_i) && $stable(pc_i))
    else $error("fetch changed its instruction during a stall");

endmodule

`default_nettype wire

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
  input  wire logic              clk_i,
  input  wire logic              rst_n_i,
  input  wire logic              valid_i,
  input  decode_pkg::word_t      instr_i,
  input  decode_pkg::word_t      pc_i,
  output logic                   stall_o,
  input  wire logic              flush_i,
  input  wire logic              credit_i,
  input  wire logic              wb_en_i,
  input  decode_pkg::reg_addr_t  wb_addr_i,
  input  decode_pkg::word_t      wb_data_i,
  output logic                   ex_valid_o,
  output decode_pkg::alu_op_t    ex_alu_op_o,
  output logic                   ex_alu_b_imm_o,
  output logic                   ex_mem_read_o,
  output logic                   ex_mem_write_o,
  output logic                   ex_reg_write_o,
  output logic                   ex_branch_o,
  output decode_pkg::reg_addr_t  ex_dest_o,
  output decode_pkg::reg_addr_t  ex_src1_o,
  output decode_pkg::reg_addr_t  ex_src2_o,
  output decode_pkg::word_t      ex_op1_o,
  output decode_pkg::word_t      ex_op2_o,
  output decode_pkg::word_t      ex_store_data_o,
  output decode_pkg::word_t      ex_imm_o,
  output decode_pkg::word_t      ex_pc_o
);

  import decode_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // internal nets
  ////////////////////////////////////////////////////////////////////////////

  opcode_t   opcode;
  reg_addr_t rd;
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rs3;
  word_t     imm;
  word_t     rd_data1;
  word_t     rd_data2;
  word_t     rd_data3;

  logic      hazard;
  logic      has_credit;
  logic      issue;
  alu_op_t   alu_op;
  logic      alu_b_imm;
  logic      mem_read;
  logic      mem_write;
  logic      reg_write;
  logic      branch;
  logic      override_en;
  reg_addr_t override_addr;

  // store data port reads rd, or rd+1 on the second STP beat
  assign rs3 = override_en ? override_addr : rd;

  field_decoder field_decoder_inst (
    .instr_i  (instr_i),
    .opcode_o (opcode),
    .rd_o     (rd),
    .rs1_o    (rs1),
    .rs2_o    (rs2),
    .imm_o    (imm)
  );

  decode_controller controller_inst (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .valid_i         (valid_i),
    .opcode_i        (opcode),
    .rd_i            (rd),
    .hazard_i        (hazard),
    .has_credit_i    (has_credit),
    .flush_i         (flush_i),
    .issue_o         (issue),
    .stall_o         (stall_o),
    .alu_op_o        (alu_op),
    .alu_b_imm_o     (alu_b_imm),
    .mem_read_o      (mem_read),
    .mem_write_o     (mem_write),
    .reg_write_o     (reg_write),
    .branch_o        (branch),
    .override_en_o   (override_en),
    .override_addr_o (override_addr)
  );

  // stores read rs3, so only they check it against the load in execute
  hazard_detector hazard_detector_inst (
    .ex_valid_i    (ex_valid_o),
    .ex_mem_read_i (ex_mem_read_o),
    .ex_dest_i     (ex_dest_o),
    .rs1_i         (rs1),
    .rs2_i         (rs2),
    .rs3_i         (rs3),
    .uses_rs3_i    (mem_write),
    .hazard_o      (hazard)
  );

  reg_file reg_file_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .wb_en_i    (wb_en_i),
    .wb_addr_i  (wb_addr_i),
    .wb_data_i  (wb_data_i),
    .rd_addr1_i (rs1),
    .rd_addr2_i (rs2),
    .rd_addr3_i (rs3),
    .rd_data1_o (rd_data1),
    .rd_data2_o (rd_data2),
    .rd_data3_o (rd_data3)
  );

  decode_exe_reg decode_exe_reg_inst (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .flush_i         (flush_i),
    .issue_i         (issue),
    .credit_i        (credit_i),
    .has_credit_o    (has_credit),
    .alu_op_i        (alu_op),
    .alu_b_imm_i     (alu_b_imm),
    .mem_read_i      (mem_read),
    .mem_write_i     (mem_write),
    .reg_write_i     (reg_write),
    .branch_i        (branch),
    .dest_i          (rd),
    .src1_i          (rs1),
    .src2_i          (rs2),
    .op1_i           (rd_data1),
    .op2_i           (rd_data2),
    .store_data_i    (rd_data3),
    .imm_i           (imm),
    .pc_i            (pc_i),
    .ex_valid_o      (ex_valid_o),
    .ex_alu_op_o     (ex_alu_op_o),
    .ex_alu_b_imm_o  (ex_alu_b_imm_o),
    .ex_mem_read_o   (ex_mem_read_o),
    .ex_mem_write_o  (ex_mem_write_o),
    .ex_reg_write_o  (ex_reg_write_o),
    .ex_branch_o     (ex_branch_o),
    .ex_dest_o       (ex_dest_o),
    .ex_src1_o       (ex_src1_o),
    .ex_src2_o       (ex_src2_o),
    .ex_op1_o        (ex_op1_o),
    .ex_op2_o        (ex_op2_o),
    .ex_store_data_o (ex_store_data_o),
    .ex_imm_o        (ex_imm_o),
    .ex_pc_o         (ex_pc_o)
  );

endmodule

`default_nettype wire

// ==== rtl/decode_exe_reg.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "decode_settings.svh"

module decode_exe_reg (
  input  wire logic              clk_i,
  input  wire logic              rst_n_i,
  input  wire logic              flush_i,
  input  wire logic              issue_i,
  input  wire logic              credit_i,
  output logic                   has_credit_o,
  input  decode_pkg::alu_op_t    alu_op_i,
  input  wire logic              alu_b_imm_i,
  input  wire logic              mem_read_i,
  input  wire logic              mem_write_i,
  input  wire logic              reg_write_i,
  input  wire logic              branch_i,
  input  decode_pkg::reg_addr_t  dest_i,
  input  decode_pkg::reg_addr_t  src1_i,
  input  decode_pkg::reg_addr_t  src2_i,
  input  decode_pkg::word_t      op1_i,
  input  decode_pkg::word_t      op2_i,
  input  decode_pkg::word_t      store_data_i,
  input  decode_pkg::word_t      imm_i,
  input  decode_pkg::word_t      pc_i,
  output logic                   ex_valid_o,
  output decode_pkg::alu_op_t    ex_alu_op_o,
  output logic                   ex_alu_b_imm_o,
  output logic                   ex_mem_read_o,
  output logic                   ex_mem_write_o,
  output logic                   ex_reg_write_o,
  output logic                   ex_branch_o,
  output decode_pkg::reg_addr_t  ex_dest_o,
  output decode_pkg::reg_addr_t  ex_src1_o,
  output decode_pkg::reg_addr_t  ex_src2_o,
  output decode_pkg::word_t      ex_op1_o,
  output decode_pkg::word_t      ex_op2_o,
  output decode_pkg::word_t      ex_store_data_o,
  output decode_pkg::word_t      ex_imm_o,
  output decode_pkg::word_t      ex_pc_o
);

  import decode_pkg::*;

  credit_cnt_t credit_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // credits
  ////////////////////////////////////////////////////////////////////////////

  // a credit coming back this cycle can be spent right away
  assign has_credit_o = (credit_cnt != '0) || credit_i;

  // flush leaves the count alone, execute still returns in-flight credits
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credit_cnt <= credit_cnt_t'(`DEC_CREDITS);
    end else begin
      case ({credit_i, issue_i})
        2'b10:   credit_cnt <= credit_cnt + credit_cnt_t'(1);
        2'b01:   credit_cnt <= credit_cnt - credit_cnt_t'(1);
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // pipeline register
  ////////////////////////////////////////////////////////////////////////////

  // valid is a one-cycle pulse per issued beat
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ex_valid_o     <= 1'b0;
      ex_mem_read_o  <= 1'b0;
      ex_mem_write_o <= 1'b0;
      ex_reg_write_o <= 1'b0;
      ex_branch_o    <= 1'b0;
    end else begin
      ex_valid_o <= issue_i && !flush_i;
      if (issue_i) begin
        ex_mem_read_o  <= mem_read_i;
        ex_mem_write_o <= mem_write_i;
        ex_reg_write_o <= reg_write_i;
        ex_branch_o    <= branch_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_i) begin
      ex_alu_op_o     <= alu_op_i;
      ex_alu_b_imm_o  <= alu_b_imm_i;
      ex_dest_o       <= dest_i;
      ex_src1_o       <= src1_i;
      ex_src2_o       <= src2_i;
      ex_op1_o        <= op1_i;
      ex_op2_o        <= op2_i;
      ex_store_data_o <= store_data_i;
      ex_imm_o        <= imm_i;
      ex_pc_o         <= pc_i;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "decode_settings.svh"

module reg_file (
  input  wire logic              clk_i,
  input  wire logic              rst_n_i,
  input  wire logic              wb_en_i,
  input  decode_pkg::reg_addr_t  wb_addr_i,
  input  decode_pkg::word_t      wb_data_i,
  input  decode_pkg::reg_addr_t  rd_addr1_i,
  input  decode_pkg::reg_addr_t  rd_addr2_i,
  input  decode_pkg::reg_addr_t  rd_addr3_i,
  output decode_pkg::word_t      rd_data1_o,
  output decode_pkg::word_t      rd_data2_o,
  output decode_pkg::word_t      rd_data3_o
);

  import decode_pkg::*;

  localparam int NUM_REGS = 1 << `DEC_ADDR_W;

  word_t regs [NUM_REGS];
  logic  wb_live;

  // writes to r0 are dropped
  assign wb_live = wb_en_i && (wb_addr_i != '0);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_live) begin
      regs[wb_addr_i] <= wb_data_i;
    end
  end

  // writeback data wins on an address match
  function automatic word_t read_port(reg_addr_t addr);
    word_t data;
    if (addr == '0) data = '0;
    else if (wb_live && (wb_addr_i == addr)) data = wb_data_i;
    else data = regs[addr];
    return data;
  endfunction

  always_comb begin
    rd_data1_o = read_port(rd_addr1_i);
    rd_data2_o = read_port(rd_addr2_i);
    rd_data3_o = read_port(rd_addr3_i);
  end

endmodule

`default_nettype wire

// ==== rtl/hazard_detector.sv ====
`timescale 1ns/1ns
`default_nettype none

module hazard_detector (
  input  wire logic              ex_valid_i,
  input  wire logic              ex_mem_read_i,
  input  decode_pkg::reg_addr_t  ex_dest_i,
  input  decode_pkg::reg_addr_t  rs1_i,
  input  decode_pkg::reg_addr_t  rs2_i,
  input  decode_pkg::reg_addr_t  rs3_i,
  input  wire logic              uses_rs3_i,
  output logic                   hazard_o
);

  logic load_in_ex;
  logic src_match;

  // a load to r0 produces nothing anyone can wait for
  assign load_in_ex = ex_valid_i && ex_mem_read_i && (ex_dest_i != '0);

  // rs3 only counts when the store actually reads it
  assign src_match = (ex_dest_i == rs1_i)
                  || (ex_dest_i == rs2_i)
                  || (uses_rs3_i && (ex_dest_i == rs3_i));

  assign hazard_o = load_in_ex && src_match;

endmodule

`default_nettype wire

// ==== rtl/field_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module field_decoder (
  input  decode_pkg::word_t      instr_i,
  output decode_pkg::opcode_t    opcode_o,
  output decode_pkg::reg_addr_t  rd_o,
  output decode_pkg::reg_addr_t  rs1_o,
  output decode_pkg::reg_addr_t  rs2_o,
  output decode_pkg::word_t      imm_o
);

  import decode_pkg::*;

  logic imm_form;

  // unused opcode space falls back to NOP
  assign opcode_o = (instr_i[15:12] <= 4'(BEQZ)) ? opcode_t'(instr_i[15:12]) : NOP;

  assign rd_o  = instr_i[11:8];
  assign rs1_o = instr_i[7:4];

  // bits 3..0 hold an immediate here, not a register
  assign imm_form = opcode_o inside {ADDI, LD, ST, STP, BEQZ};

  // r0 never matches a load destination, so no false hazard
  assign rs2_o = imm_form ? reg_addr_t'(0) : instr_i[3:0];

  assign imm_o = {{($bits(word_t)-4){instr_i[3]}}, instr_i[3:0]};

endmodule

`default_nettype wire

// ==== rtl/decode_controller.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_controller (
  input  wire logic                clk_i,
  input  wire logic                rst_n_i,
  input  wire logic                valid_i,
  input  decode_pkg::opcode_t      opcode_i,
  input  decode_pkg::reg_addr_t    rd_i,
  input  wire logic                hazard_i,
  input  wire logic                has_credit_i,
  input  wire logic                flush_i,
  output logic                     issue_o,
  output logic                     stall_o,
  output decode_pkg::alu_op_t      alu_op_o,
  output logic                     alu_b_imm_o,
  output logic                     mem_read_o,
  output logic                     mem_write_o,
  output logic                     reg_write_o,
  output logic                     branch_o,
  output logic                     override_en_o,
  output decode_pkg::reg_addr_t    override_addr_o
);

  import decode_pkg::*;

  ctrl_state_t state;
  logic        is_stp;
  logic        final_beat;

  ////////////////////////////////////////////////////////////////////////////
  // opcode table
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    alu_op_o    = ALU_ADD;
    alu_b_imm_o = 1'b0;
    mem_read_o  = 1'b0;
    mem_write_o = 1'b0;
    reg_write_o = 1'b0;
    branch_o    = 1'b0;
    case (opcode_i)
      ADD: reg_write_o = 1'b1;
      SUB: begin
        alu_op_o    = ALU_SUB;
        reg_write_o = 1'b1;
      end
      AND: begin
        alu_op_o    = ALU_AND;
        reg_write_o = 1'b1;
      end
      OR: begin
        alu_op_o    = ALU_OR;
        reg_write_o = 1'b1;
      end
      ADDI: begin
        alu_b_imm_o = 1'b1;
        reg_write_o = 1'b1;
      end
      LD: begin
        alu_b_imm_o = 1'b1;
        mem_read_o  = 1'b1;
        reg_write_o = 1'b1;
      end
      // both beats of a store pair compute base plus immediate
      ST, STP: begin
        alu_b_imm_o = 1'b1;
        mem_write_o = 1'b1;
      end
      BEQZ: begin
        alu_op_o = ALU_SUB;
        branch_o = 1'b1;
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // issue and stall
  ////////////////////////////////////////////////////////////////////////////

  assign is_stp     = (opcode_i == STP);
  assign final_beat = !is_stp || (state == CTRL_STP_SECOND);

  assign issue_o = valid_i && has_credit_i && !hazard_i && !flush_i;

  // fetch holds the instruction until its last beat has issued
  assign stall_o = valid_i && !(issue_o && final_beat);

  // second STP beat reads rd+1 through the source-3 port
  assign override_en_o   = (state == CTRL_STP_SECOND);
  assign override_addr_o = rd_i + reg_addr_t'(1);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state <= CTRL_SINGLE;
    end else if (flush_i) begin
      state <= CTRL_SINGLE;
    end else if (issue_o) begin
      if (state == CTRL_SINGLE && is_stp) begin
        state <= CTRL_STP_SECOND;
      end else begin
        state <= CTRL_SINGLE;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/decode_pkg.sv ====
`default_nettype none

`include "decode_settings.svh"

package decode_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths with a meaning
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [`DEC_WORD-1:0]   word_t;
  typedef logic [`DEC_ADDR_W-1:0] reg_addr_t;

  // wide enough to hold 0..DEC_CREDITS
  typedef logic [$clog2(`DEC_CREDITS+1)-1:0] credit_cnt_t;

  ////////////////////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////////////////////

  // instr[15:12], codes above BEQZ decode as NOP
  typedef enum logic [3:0] {
    NOP  = 4'd0,
    ADD  = 4'd1,
    SUB  = 4'd2,
    AND  = 4'd3,
    OR   = 4'd4,
    ADDI = 4'd5,
    LD   = 4'd6,
    ST   = 4'd7,
    STP  = 4'd8,
    BEQZ = 4'd9
  } opcode_t;

  typedef enum logic [1:0] {
    ALU_ADD = 2'd0,
    ALU_SUB = 2'd1,
    ALU_AND = 2'd2,
    ALU_OR  = 2'd3
  } alu_op_t;

  // second state only while the rd+1 beat of a store pair is pending
  typedef enum logic {
    CTRL_SINGLE     = 1'b0,
    CTRL_STP_SECOND = 1'b1
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== rtl/decode_settings.svh ====
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// decode stage widths
////////////////////////////////////////////////////////////////////////////

// data and instruction width
`define DEC_WORD 16

// register index width, sixteen registers
`define DEC_ADDR_W 4

// entries execute can buffer, also the credit count after reset
`define DEC_CREDITS 2

`endif
